// File: common/dmix_params.svh
`ifndef DMIX_PARAMS_SVH
`define DMIX_PARAMS_SVH

// audio sample width as delivered by the receivers
`define DMIX_SW 24

// volume width, unsigned Q8.8
// 16'h0100 is unity gain
`define DMIX_VW 16

// ring buffer depth is 2**DMIX_DEPTH_LOG2 entries
`define DMIX_DEPTH_LOG2 4

// clk245760 cycles per half bck period
// 32 bck per half-frame, so a half-frame is 256 cycles
`define DMIX_BCK_HALF 4

// number of receiver inputs when the top is not overridden
`define DMIX_NUM_IN 2

`endif

// File: common/dmix_pkg.sv
`default_nettype none

`include "dmix_params.svh"

package dmix_pkg;

    // audio side, matches the I2S lrck level
    // left half-frame has lrck low
    typedef enum logic {
        SIDE_L = 1'b0,
        SIDE_R = 1'b1
    } side_e;

    // one decoded word from a receiver
    // wpulse marks a new sample for the side in lrck
    typedef struct packed {
        logic                 wpulse;
        side_e                lrck;
        logic [`DMIX_SW-1:0]  data;
    } dai_word_t;

    // per-input gain, unsigned Q8.8 for each side
    typedef struct packed {
        logic [`DMIX_VW-1:0]  vol_l;
        logic [`DMIX_VW-1:0]  vol_r;
    } vol_t;

    // mixer sequencing
    // POP and MAC alternate once per input
    typedef enum logic [1:0] {
        MIX_IDLE = 2'd0,
        MIX_POP  = 2'd1,
        MIX_MAC  = 2'd2,
        MIX_DONE = 2'd3
    } mix_state_e;

endpackage

`default_nettype wire

// File: ringbuf/ringbuf.sv
`timescale 1ns/10ps
`default_nettype none

`include "dmix_params.svh"

module ringbuf (
    input  wire logic                 clk245760,
    input  wire logic                 rst,
    input  wire logic                 we_i,
    input  wire logic [`DMIX_SW-1:0]  data_i,
    input  wire logic                 pop_i,
    output logic                      ack_o,
    output logic [`DMIX_SW-1:0]       data_o
);

    localparam int AW    = `DMIX_DEPTH_LOG2;
    localparam int DEPTH = 1 << AW;

    logic [`DMIX_SW-1:0] mem [DEPTH];

    // extra msb on each pointer tells full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic [AW:0] fill;
    logic        empty;
    logic        full;

    assign fill  = wr_ptr - rd_ptr;
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // sample storage, a write while full is lost
    always_ff @(posedge clk245760) begin
        if (we_i && !full) begin
            mem[wr_ptr[AW-1:0]] <= data_i;
        end
    end

    always_ff @(posedge clk245760) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            ack_o  <= 1'b0;
        end else begin
            ack_o <= pop_i;
            if (we_i && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // underrun answers with silence
    always_ff @(posedge clk245760) begin
        if (pop_i) begin
            data_o <= empty ? '0 : mem[rd_ptr[AW-1:0]];
        end
    end

    // consumer waits for the one-cycle answer before it pops again
    a_one_pop_per_ack: assert property (
        @(posedge clk245760) disable iff (rst)
        pop_i |=> !pop_i
    ) else $error("ringbuf popped again before its ack");

    a_fill_bound: assert property (
        @(posedge clk245760) disable iff (rst)
        fill <= DEPTH
    ) else $error("ringbuf pointer distance beyond depth");

endmodule

`default_nettype wire

// File: mixer/mixer.sv
`timescale 1ns/10ps
`default_nettype none

`include "dmix_params.svh"

module mixer #(
    parameter int NUM_IN = `DMIX_NUM_IN
) (
    input  wire logic                               clk245760,
    input  wire logic                               rst,
    input  wire logic [1:0]                         pop_i,
    input  wire dmix_pkg::vol_t                     vol_i [NUM_IN],
    input  wire logic [NUM_IN-1:0]                  buf_ack_i,
    input  wire logic [NUM_IN-1:0][`DMIX_SW-1:0]    buf_data_i,
    output logic [NUM_IN-1:0][1:0]                  buf_pop_o,
    output logic [1:0]                              ack_o,
    output logic [`DMIX_SW-1:0]                     data_o
);

    localparam int SW     = `DMIX_SW;
    localparam int VW     = `DMIX_VW;
    localparam int PROD_W = SW + VW + 1;
    localparam int ACC_W  = SW + VW + 2;
    localparam int FRAC   = 8;
    localparam int IDX_W  = (NUM_IN > 1) ? $clog2(NUM_IN) : 1;

    dmix_pkg::mix_state_e     state;
    dmix_pkg::side_e          side_q;
    logic [IDX_W-1:0]         idx;
    logic [1:0]               pending;
    logic [1:0]               req;
    logic [VW-1:0]            vol_sel;
    logic signed [PROD_W-1:0] prod;
    logic signed [ACC_W-1:0]  acc;
    logic signed [ACC_W-1:0]  acc_sh;
    logic [SW-1:0]            sat;

    // requests seen now plus any held back while busy
    assign req = pending | pop_i;

    always_comb begin
        if (side_q == dmix_pkg::SIDE_L) begin
            vol_sel = vol_i[idx].vol_l;
        end else begin
            vol_sel = vol_i[idx].vol_r;
        end
    end

    // volume is unsigned, zero-extend before the signed multiply
    assign prod = $signed(buf_data_i[idx]) * $signed({1'b0, vol_sel});

    // drop the Q8.8 fraction, then clamp to 24 bits
    assign acc_sh = acc >>> FRAC;

    always_comb begin
        if (~|acc_sh[ACC_W-1:SW-1] || &acc_sh[ACC_W-1:SW-1]) begin
            sat = acc_sh[SW-1:0];
        end else if (acc_sh[ACC_W-1]) begin
            sat = {1'b1, {(SW-1){1'b0}}};
        end else begin
            sat = {1'b0, {(SW-1){1'b1}}};
        end
    end

    always_comb begin
        buf_pop_o = '0;
        if (state == dmix_pkg::MIX_POP) begin
            buf_pop_o[idx][side_q] = 1'b1;
        end
    end

    always_ff @(posedge clk245760) begin
        if (rst) begin
            state   <= dmix_pkg::MIX_IDLE;
            side_q  <= dmix_pkg::SIDE_L;
            idx     <= '0;
            pending <= '0;
            ack_o   <= '0;
        end else begin
            ack_o   <= '0;
            pending <= req;
            case (state)
                dmix_pkg::MIX_IDLE: begin
                    if (req != 2'b00) begin
                        // left wins when both sides wait
                        if (req[dmix_pkg::SIDE_L]) begin
                            side_q                     <= dmix_pkg::SIDE_L;
                            pending[dmix_pkg::SIDE_L]  <= 1'b0;
                        end else begin
                            side_q                     <= dmix_pkg::SIDE_R;
                            pending[dmix_pkg::SIDE_R]  <= 1'b0;
                        end
                        idx   <= '0;
                        state <= dmix_pkg::MIX_POP;
                    end
                end
                dmix_pkg::MIX_POP: begin
                    state <= dmix_pkg::MIX_MAC;
                end
                dmix_pkg::MIX_MAC: begin
                    if (buf_ack_i[idx]) begin
                        if (idx == IDX_W'(NUM_IN - 1)) begin
                            state <= dmix_pkg::MIX_DONE;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= dmix_pkg::MIX_POP;
                        end
                    end
                end
                dmix_pkg::MIX_DONE: begin
                    ack_o[side_q] <= 1'b1;
                    state         <= dmix_pkg::MIX_IDLE;
                end
                default: begin
                    state <= dmix_pkg::MIX_IDLE;
                end
            endcase
        end
    end

    // accumulator restarts with each request
    always_ff @(posedge clk245760) begin
        if (state == dmix_pkg::MIX_IDLE) begin
            acc <= '0;
        end else if (state == dmix_pkg::MIX_MAC && buf_ack_i[idx]) begin
            acc <= acc + prod;
        end
        if (state == dmix_pkg::MIX_DONE) begin
            data_o <= sat;
        end
    end

    // buffers answer only while the FSM waits for them
    a_buf_ack_in_mac: assert property (
        @(posedge clk245760) disable iff (rst)
        (|buf_ack_i) |-> (state == dmix_pkg::MIX_MAC)
    ) else $error("mixer buffer ack outside MIX_MAC");

    // a repeated request for a waiting side would be lost
    a_no_request_overrun: assert property (
        @(posedge clk245760) disable iff (rst)
        (pop_i & pending) == 2'b00
    ) else $error("mixer request for a side that is already waiting");

endmodule

`default_nettype wire

// File: dac_drv/dac_drv.sv
`timescale 1ns/10ps
`default_nettype none

`include "dmix_params.svh"

module dac_drv (
    input  wire logic                 clk245760,
    input  wire logic                 rst,
    input  wire logic [1:0]           ack_i,
    input  wire logic [`DMIX_SW-1:0]  data_i,
    output logic [1:0]                pop_o,
    output logic                      sck_o,
    output logic                      bck_o,
    output logic                      lrck_o,
    output logic                      data_o
);

    localparam int SW      = `DMIX_SW;
    localparam int SLOT    = 32;
    localparam int TAIL    = SLOT - 1 - SW;
    localparam int BCK_BIT = $clog2(`DMIX_BCK_HALF);
    localparam int HALF_W  = $clog2(SLOT * 2 * `DMIX_BCK_HALF);
    localparam int CNT_W   = HALF_W + 1;

    // one count per clk245760 cycle, wraps once per frame
    logic [CNT_W-1:0] cnt;
    logic [SLOT-1:0]  shreg;
    logic [1:0][SW-1:0] hold;
    logic [1:0]       outstanding;
    logic             half_end;
    logic             bit_end;

    assign half_end = &cnt[HALF_W-1:0];
    // last cycle of bck high, falling edge follows
    assign bit_end  = &cnt[BCK_BIT:0];

    assign sck_o  = cnt[0];
    assign bck_o  = cnt[BCK_BIT];
    assign lrck_o = cnt[CNT_W-1];
    assign data_o = shreg[SLOT-1];

    always_ff @(posedge clk245760) begin
        if (rst) begin
            cnt         <= '0;
            shreg       <= '0;
            hold        <= '0;
            pop_o       <= '0;
            outstanding <= '0;
        end else begin
            cnt         <= cnt + 1'b1;
            pop_o       <= '0;
            outstanding <= (outstanding | pop_o) & ~ack_i;

            if (ack_i[dmix_pkg::SIDE_L]) begin
                hold[dmix_pkg::SIDE_L] <= data_i;
            end
            if (ack_i[dmix_pkg::SIDE_R]) begin
                hold[dmix_pkg::SIDE_R] <= data_i;
            end

            if (half_end) begin
                // slot 0 is the I2S delay bit, then msb first, then zero fill
                // request the other side a half-frame ahead
                if (lrck_o == dmix_pkg::SIDE_R) begin
                    shreg <= {1'b0, hold[dmix_pkg::SIDE_L], {TAIL{1'b0}}};
                    pop_o[dmix_pkg::SIDE_R] <= 1'b1;
                end else begin
                    shreg <= {1'b0, hold[dmix_pkg::SIDE_R], {TAIL{1'b0}}};
                    pop_o[dmix_pkg::SIDE_L] <= 1'b1;
                end
            end else if (bit_end) begin
                shreg <= {shreg[SLOT-2:0], 1'b0};
            end
        end
    end

    a_ack_has_pop: assert property (
        @(posedge clk245760) disable iff (rst)
        (ack_i & ~outstanding) == 2'b00
    ) else $error("dac_drv got an ack with no pop outstanding");

endmodule

`default_nettype wire

// File: design/dmix_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "dmix_params.svh"

module dmix_top #(
    parameter int NUM_IN = `DMIX_NUM_IN
) (
    input  wire logic                 clk245760,
    input  wire logic                 rst,
    input  wire dmix_pkg::dai_word_t  dai_i [NUM_IN],
    input  wire dmix_pkg::vol_t       vol_i [NUM_IN],
    output wire logic                 dac_sck_o,
    output wire logic                 dac_bck_o,
    output wire logic                 dac_lrck_o,
    output wire logic                 dac_data_o
);

    wire [NUM_IN-1:0][1:0]                we;
    wire [NUM_IN-1:0][1:0]                rb_pop;
    wire [NUM_IN-1:0][1:0]                rb_ack;
    wire [NUM_IN-1:0][1:0][`DMIX_SW-1:0]  rb_data;
    wire [NUM_IN-1:0]                     buf_ack;
    wire [NUM_IN-1:0][`DMIX_SW-1:0]       buf_data;
    wire [1:0]                            mix_pop;
    wire [1:0]                            mix_ack;
    wire [`DMIX_SW-1:0]                   mix_data;

    for (genvar i = 0; i < NUM_IN; i++) begin : g_in
        // route each receiver word to the buffer of its side
        assign we[i][dmix_pkg::SIDE_L] = dai_i[i].wpulse &&
                                         (dai_i[i].lrck == dmix_pkg::SIDE_L);
        assign we[i][dmix_pkg::SIDE_R] = dai_i[i].wpulse &&
                                         (dai_i[i].lrck == dmix_pkg::SIDE_R);

        for (genvar s = 0; s < 2; s++) begin : g_side
            ringbuf u_rb (
                .clk245760 (clk245760),
                .rst       (rst),
                .we_i      (we[i][s]),
                .data_i    (dai_i[i].data),
                .pop_i     (rb_pop[i][s]),
                .ack_o     (rb_ack[i][s]),
                .data_o    (rb_data[i][s])
            );
        end

        // mixer pops one side at a time, so merge the two answers
        assign buf_ack[i]  = |rb_ack[i];
        assign buf_data[i] = rb_ack[i][dmix_pkg::SIDE_R] ? rb_data[i][dmix_pkg::SIDE_R]
                                                         : rb_data[i][dmix_pkg::SIDE_L];
    end

    mixer #(
        .NUM_IN (NUM_IN)
    ) u_mixer (
        .clk245760  (clk245760),
        .rst        (rst),
        .pop_i      (mix_pop),
        .vol_i      (vol_i),
        .buf_ack_i  (buf_ack),
        .buf_data_i (buf_data),
        .buf_pop_o  (rb_pop),
        .ack_o      (mix_ack),
        .data_o     (mix_data)
    );

    dac_drv u_dac_drv (
        .clk245760 (clk245760),
        .rst       (rst),
        .ack_i     (mix_ack),
        .data_i    (mix_data),
        .pop_o     (mix_pop),
        .sck_o     (dac_sck_o),
        .bck_o     (dac_bck_o),
        .lrck_o    (dac_lrck_o),
        .data_o    (dac_data_o)
    );

endmodule

`default_nettype wire

// File: test/tb_dmix.sv
`timescale 1ns/10ps
`default_nettype none

`include "dmix_params.svh"

module tb_dmix;

    localparam int NUM_IN  = 2;
    localparam int NFRAMES = 24;
    localparam int COLS    = 9;
    // every frame is 512 clocks of 100 ns, plus two frames and some slack
    localparam longint WATCHDOG_NS = longint'(NFRAMES + 2) * 512 * 100 + 20000;

    logic                 clk245760;
    logic                 rst;
    dmix_pkg::dai_word_t  dai [NUM_IN];
    dmix_pkg::vol_t       vol [NUM_IN];
    wire                  dac_sck;
    wire                  dac_bck;
    wire                  dac_lrck;
    wire                  dac_data;

    // one row per output frame, see the column note in the data file
    logic [31:0]          stim [NFRAMES*COLS];

    int                   nerr;
    int                   nchecks;
    int                   halves;
    int                   slot;
    int                   k;
    int                   sck_rises;
    logic                 done;
    logic                 prev_bck;
    logic                 prev_sck;
    logic                 bck_seen;
    logic                 half_lrck;
    logic [`DMIX_SW-1:0]  word;
    logic [7:0]           pad;

    dmix_top #(
        .NUM_IN (NUM_IN)
    ) u_dut (
        .clk245760  (clk245760),
        .rst        (rst),
        .dai_i      (dai),
        .vol_i      (vol),
        .dac_sck_o  (dac_sck),
        .dac_bck_o  (dac_bck),
        .dac_lrck_o (dac_lrck),
        .dac_data_o (dac_data)
    );

    initial begin
        clk245760 = 1'b0;
        forever #50 clk245760 = ~clk245760;
    end

    function automatic dmix_pkg::dai_word_t pack_word(input logic we,
                                                      input dmix_pkg::side_e side,
                                                      input logic [31:0] sample);
        dmix_pkg::dai_word_t w;
        w.wpulse = we;
        w.lrck   = side;
        w.data   = sample[`DMIX_SW-1:0];
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        nchecks++;
        if (got !== exp) begin
            nerr++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    // receiver words and volumes for one output frame
    task automatic write_frame(input int line);
        logic [31:0] f;
        int          base;
        base   = line * COLS;
        f      = stim[base];
        vol[0] = stim[base+5];
        vol[1] = stim[base+6];
        dai[0] = pack_word(f[0], dmix_pkg::SIDE_L, stim[base+1]);
        dai[1] = pack_word(f[2], dmix_pkg::SIDE_L, stim[base+3]);
        @(negedge clk245760);
        dai[0] = pack_word(f[1], dmix_pkg::SIDE_R, stim[base+2]);
        dai[1] = pack_word(f[3], dmix_pkg::SIDE_R, stim[base+4]);
        @(negedge clk245760);
        dai[0] = '0;
        dai[1] = '0;
        // 17 left samples of input 0 back to back, taken from this row on
        if (f[4]) begin
            for (int n = 0; n < 17; n++) begin
                dai[0] = pack_word(1'b1, dmix_pkg::SIDE_L, stim[(line+n)*COLS+1]);
                @(negedge clk245760);
            end
            dai[0] = '0;
        end
    endtask

    task automatic wait_frame_start();
        while (dac_lrck !== 1'b1) @(negedge clk245760);
        while (dac_lrck !== 1'b0) @(negedge clk245760);
    endtask

    task automatic check_half();
        int          frame;
        logic [31:0] exp;
        frame = halves / 2;
        if (half_lrck == dmix_pkg::SIDE_L) begin
            exp = stim[frame*COLS+7];
        end else begin
            exp = stim[frame*COLS+8];
        end
        check_value($sformatf("dac_data_o frame %0d %s", frame, half_lrck ? "right" : "left"),
                    32'(word), exp);
        check_value($sformatf("dac_data_o pad bits frame %0d", frame), 32'(pad), 32'h0);
        halves++;
        if (halves == 2 * NFRAMES) begin
            done = 1'b1;
        end
    endtask

    // serial capture, bck rising edges seen from the falling clock edge
    always @(negedge clk245760) begin
        if (!rst && !done && dac_sck && !prev_sck) begin
            sck_rises = sck_rises + 1;
        end
        if (!rst && !done && dac_bck && !prev_bck) begin
            // sck at 256 fs and bck at 64 fs
            if (bck_seen) begin
                check_value("dac_sck_o rises per bck", 32'(sck_rises), 32'd4);
            end
            bck_seen  = 1'b1;
            sck_rises = 0;
            if (dac_lrck != half_lrck) begin
                half_lrck = dac_lrck;
                slot      = 0;
            end else begin
                slot = slot + 1;
            end
            if (slot >= 1 && slot <= `DMIX_SW) begin
                word = {word[`DMIX_SW-2:0], dac_data};
            end else begin
                pad = {pad[6:0], dac_data};
            end
            if (slot == 31) begin
                check_half();
            end
        end
        prev_bck = dac_bck;
        prev_sck = dac_sck;
    end

    initial begin
        rst       = 1'b1;
        dai[0]    = '0;
        dai[1]    = '0;
        vol[0]    = '0;
        vol[1]    = '0;
        nerr      = 0;
        nchecks   = 0;
        halves    = 0;
        slot      = 0;
        sck_rises = 0;
        done      = 1'b0;
        prev_bck  = 1'b0;
        prev_sck  = 1'b0;
        bck_seen  = 1'b0;
        half_lrck = 1'b1;
        word      = '0;
        pad       = '0;
        $readmemh("test/dmix_stimulus.txt", stim);
        repeat (3) @(posedge clk245760);
        @(negedge clk245760);
        check_value("dac_lrck_o", 32'(dac_lrck), 32'h0);
        check_value("dac_bck_o", 32'(dac_bck), 32'h0);
        check_value("dac_sck_o", 32'(dac_sck), 32'h0);
        check_value("dac_data_o", 32'(dac_data), 32'h0);
        rst = 1'b0;
        // row k is written during output frame k-1, row 0 stays silent
        for (k = 1; k < NFRAMES; k++) begin
            if (k > 1) begin
                wait_frame_start();
            end
            repeat (64) @(negedge clk245760);
            write_frame(k);
        end
        wait (done);
        $display("checks run: %0d, errors: %0d", nchecks, nerr);
        if (nerr == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: DAC output stalled after %0d of %0d half-frames",
                 halves, 2 * NFRAMES);
        $display("checks run: %0d, errors: %0d", nchecks, nerr);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/dmix_stimulus.txt
// flags in0_l in0_r in1_l in1_r vol0 vol1 exp_l exp_r, one output frame per row
// flags bit0..3 write in0_l in0_r in1_l in1_r and bit4 bursts 17 in0_l samples from this row on
00 000000 000000 000000 000000 00000000 00000000 000000 000000
0f 123456 fedcba 555555 aaaaaa 01000100 00000000 123456 fedcba
0f 100000 fffffb 020000 fffff8 00800080 01800180 0b0000 fffff1
0f 7ffff0 000103 800010 fffe00 01000040 00c00200 1ffffc fffc40
0f 400000 c00000 300000 d00000 04000400 04000400 7fffff 800000
0a 0000aa 000200 0000bb 000300 01000100 01000100 000000 000500
0f 000010 ffffff 000020 ffffff 01000100 01000100 000030 fffffe
1e 010101 f00001 333333 444444 01000100 00000000 010101 f00001
0e 020202 f00002 333333 444444 01000100 00000000 020202 f00002
0e 030303 f00003 333333 444444 01000100 00000000 030303 f00003
0e 040404 f00004 333333 444444 01000100 00000000 040404 f00004
0e 050505 f00005 333333 444444 01000100 00000000 050505 f00005
0e 060606 f00006 333333 444444 01000100 00000000 060606 f00006
0e 070707 f00007 333333 444444 01000100 00000000 070707 f00007
0e 080808 f00008 333333 444444 01000100 00000000 080808 f00008
0e 090909 f00009 333333 444444 01000100 00000000 090909 f00009
0e 0a0a0a f0000a 333333 444444 01000100 00000000 0a0a0a f0000a
0e 0b0b0b f0000b 333333 444444 01000100 00000000 0b0b0b f0000b
0e 0c0c0c f0000c 333333 444444 01000100 00000000 0c0c0c f0000c
0e 0d0d0d f0000d 333333 444444 01000100 00000000 0d0d0d f0000d
0e 0e0e0e f0000e 333333 444444 01000100 00000000 0e0e0e f0000e
0e 0f0f0f f0000f 333333 444444 01000100 00000000 0f0f0f f0000f
0e 101010 f00010 333333 444444 01000100 00000000 101010 f00010
0e 111111 f00011 333333 444444 01000100 00000000 000000 f00011

// File: sim.f
+incdir+common
common/dmix_pkg.sv
ringbuf/ringbuf.sv
mixer/mixer.sv
dac_drv/dac_drv.sv
design/dmix_top.sv
test/tb_dmix.sv

// File: Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_dmix -Mdir obj_dir
	./obj_dir/Vtb_dmix > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	cat $(LOG)
	! grep -q "Checks failed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
